/* hdl/traffic_analyzer_pkg.sv */
package traffic_analyzer_pkg;

    // gmii receive octet
    localparam int GMII_DATA_WIDTH = 8;

    // preamble octets and start of frame delimiter
    localparam logic [GMII_DATA_WIDTH-1:0] PREAMBLE_OCTET = 8'h55;
    localparam logic [GMII_DATA_WIDTH-1:0] SFD_OCTET      = 8'hD5;

    // seven preamble octets plus the sfd
    localparam int PREAMBLE_LEN = 8;

    // per frame size counts
    localparam int FRAME_SIZE_WIDTH = 16;

    // statistics widths
    localparam int PKT_COUNT_WIDTH   = 32;
    localparam int OCTET_COUNT_WIDTH = 64;

    // reflected ethernet crc-32, lsb first
    localparam logic [31:0] CRC_POLY = 32'hEDB88320;
    localparam logic [31:0] CRC_INIT = 32'hFFFFFFFF;

    // register value once data and a correct fcs have been shifted in
    localparam logic [31:0] CRC_RESIDUE = 32'hDEBB20E3;

endpackage

/* hdl/gmii_crc_check.sv */
`timescale 1ns/1ps

module gmii_crc_check (
    input  logic                                           clk,
    input  logic                                           resetn,
    input  logic                                           run,
    input  logic [traffic_analyzer_pkg::GMII_DATA_WIDTH-1:0] gmii_d,
    input  logic                                           gmii_en,
    input  logic                                           gmii_er,
    output logic                                           crc_ok,
    output logic                                           preamble_ok
);

    logic                                             in_frame;
    logic [$clog2(traffic_analyzer_pkg::PREAMBLE_LEN+1)-1:0] oct_cnt;
    logic [traffic_analyzer_pkg::GMII_DATA_WIDTH-1:0] exp_octet;
    logic                                             in_header;
    logic [31:0]                                      crc;
    logic                                             pre_good;
    logic                                             er_seen;

    // one octet through the reflected crc-32, lsb first
    function automatic logic [31:0] crc_step(
        input logic [31:0]                                      crc_in,
        input logic [traffic_analyzer_pkg::GMII_DATA_WIDTH-1:0] octet
    );
        logic [31:0] c;
        c = crc_in ^ {{(32 - traffic_analyzer_pkg::GMII_DATA_WIDTH){1'b0}}, octet};
        for (int i = 0; i < traffic_analyzer_pkg::GMII_DATA_WIDTH; i++) begin
            if (c[0]) begin
                c = (c >> 1) ^ traffic_analyzer_pkg::CRC_POLY;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

    // oct_cnt is zero between frames, so the first octet expects a preamble octet
    always_comb begin
        if (oct_cnt == traffic_analyzer_pkg::PREAMBLE_LEN - 1) begin
            exp_octet = traffic_analyzer_pkg::SFD_OCTET;
        end else begin
            exp_octet = traffic_analyzer_pkg::PREAMBLE_OCTET;
        end
    end

    assign in_header = (oct_cnt < traffic_analyzer_pkg::PREAMBLE_LEN);

    // frame position and the latched verdicts
    always_ff @(posedge clk) begin
        if (!resetn || !run) begin
            in_frame    <= 1'b0;
            oct_cnt     <= '0;
            crc_ok      <= 1'b0;
            preamble_ok <= 1'b0;
        end else if (gmii_en) begin
            in_frame <= 1'b1;
            if (in_header) begin
                oct_cnt <= oct_cnt + 1'b1;
            end
        end else if (in_frame) begin
            in_frame <= 1'b0;
            oct_cnt  <= '0;
            // short frames never reach the sfd
            preamble_ok <= pre_good && (oct_cnt == traffic_analyzer_pkg::PREAMBLE_LEN);
            crc_ok      <= !er_seen && (crc == traffic_analyzer_pkg::CRC_RESIDUE);
        end
    end

    // running checks, restarted at every first octet
    always_ff @(posedge clk) begin
        if (gmii_en) begin
            if (!in_frame) begin
                pre_good <= (gmii_d == exp_octet);
                er_seen  <= gmii_er;
                crc      <= traffic_analyzer_pkg::CRC_INIT;
            end else begin
                er_seen <= er_seen | gmii_er;
                if (in_header) begin
                    pre_good <= pre_good && (gmii_d == exp_octet);
                end else begin
                    // layer-2 octets including the fcs
                    crc <= crc_step(crc, gmii_d);
                end
            end
        end
    end

endmodule

/* hdl/gmii_frame_tracker.sv */
`timescale 1ns/1ps

module gmii_frame_tracker (
    input  logic                                              clk,
    input  logic                                              resetn,
    input  logic                                              run,
    input  logic                                              gmii_en,
    input  logic                                              preamble_ok,
    output logic                                              frame_done,
    output logic [traffic_analyzer_pkg::FRAME_SIZE_WIDTH-1:0] frame_size,
    output logic [traffic_analyzer_pkg::FRAME_SIZE_WIDTH-1:0] l2_size
);

    // idle when low, in frame when high
    logic                                              in_frame;
    logic [traffic_analyzer_pkg::FRAME_SIZE_WIDTH-1:0] size_cnt;
    logic [traffic_analyzer_pkg::FRAME_SIZE_WIDTH-1:0] l2_cnt;
    logic [traffic_analyzer_pkg::FRAME_SIZE_WIDTH-1:0] l2_total;

    always_ff @(posedge clk) begin
        if (!resetn || !run) begin
            in_frame   <= 1'b0;
            size_cnt   <= '0;
            l2_cnt     <= '0;
            frame_size <= '0;
            l2_total   <= '0;
            frame_done <= 1'b0;
        end else begin
            frame_done <= 1'b0;
            if (!in_frame) begin
                if (gmii_en) begin
                    // first octet of a new frame
                    in_frame <= 1'b1;
                    size_cnt <= 1;
                    l2_cnt   <= '0;
                end
            end else if (gmii_en) begin
                size_cnt <= size_cnt + 1'b1;
                // octets after the sfd
                if (size_cnt >= traffic_analyzer_pkg::PREAMBLE_LEN) begin
                    l2_cnt <= l2_cnt + 1'b1;
                end
            end else begin
                in_frame   <= 1'b0;
                frame_done <= 1'b1;
                frame_size <= size_cnt;
                l2_total   <= l2_cnt;
            end
        end
    end

    // preamble_ok is latched on the same edge as l2_total,
    // so the gate sits behind the register
    assign l2_size = preamble_ok ? l2_total : '0;

endmodule

/* hdl/traffic_stats.sv */
`timescale 1ns/1ps

module traffic_stats (
    input  logic                                               clk,
    input  logic                                               resetn,
    input  logic                                               run,
    input  logic                                               freeze,
    input  logic                                               gmii_en,
    input  logic                                               frame_done,
    input  logic [traffic_analyzer_pkg::FRAME_SIZE_WIDTH-1:0]  frame_size,
    input  logic [traffic_analyzer_pkg::FRAME_SIZE_WIDTH-1:0]  l2_size,
    input  logic                                               crc_ok,
    input  logic                                               preamble_ok,
    output logic [traffic_analyzer_pkg::PKT_COUNT_WIDTH-1:0]   pkts,
    output logic [traffic_analyzer_pkg::PKT_COUNT_WIDTH-1:0]   bad_crc_pkts,
    output logic [traffic_analyzer_pkg::PKT_COUNT_WIDTH-1:0]   bad_preamble_pkts,
    output logic [traffic_analyzer_pkg::OCTET_COUNT_WIDTH-1:0] octets,
    output logic [traffic_analyzer_pkg::OCTET_COUNT_WIDTH-1:0] bad_crc_octets,
    output logic [traffic_analyzer_pkg::OCTET_COUNT_WIDTH-1:0] bad_preamble_octets,
    output logic [traffic_analyzer_pkg::OCTET_COUNT_WIDTH-1:0] octets_idle,
    output logic [traffic_analyzer_pkg::OCTET_COUNT_WIDTH-1:0] octets_total
);

    logic en_d;
    logic freeze_sync;

    logic [traffic_analyzer_pkg::OCTET_COUNT_WIDTH-1:0] frame_octets;
    logic [traffic_analyzer_pkg::OCTET_COUNT_WIDTH-1:0] l2_octets;

    // internal counters
    logic [traffic_analyzer_pkg::PKT_COUNT_WIDTH-1:0]   pkts_cnt;
    logic [traffic_analyzer_pkg::PKT_COUNT_WIDTH-1:0]   bad_crc_pkts_cnt;
    logic [traffic_analyzer_pkg::PKT_COUNT_WIDTH-1:0]   bad_pre_pkts_cnt;
    logic [traffic_analyzer_pkg::OCTET_COUNT_WIDTH-1:0] octets_cnt;
    logic [traffic_analyzer_pkg::OCTET_COUNT_WIDTH-1:0] bad_crc_octets_cnt;
    logic [traffic_analyzer_pkg::OCTET_COUNT_WIDTH-1:0] bad_pre_octets_cnt;
    logic [traffic_analyzer_pkg::OCTET_COUNT_WIDTH-1:0] idle_cnt;
    logic [traffic_analyzer_pkg::OCTET_COUNT_WIDTH-1:0] total_cnt;

    // totals including the frame being finished
    logic [traffic_analyzer_pkg::PKT_COUNT_WIDTH-1:0]   pkts_nxt;
    logic [traffic_analyzer_pkg::PKT_COUNT_WIDTH-1:0]   bad_crc_pkts_nxt;
    logic [traffic_analyzer_pkg::PKT_COUNT_WIDTH-1:0]   bad_pre_pkts_nxt;
    logic [traffic_analyzer_pkg::OCTET_COUNT_WIDTH-1:0] octets_nxt;
    logic [traffic_analyzer_pkg::OCTET_COUNT_WIDTH-1:0] bad_crc_octets_nxt;
    logic [traffic_analyzer_pkg::OCTET_COUNT_WIDTH-1:0] bad_pre_octets_nxt;

    assign frame_octets = {{(traffic_analyzer_pkg::OCTET_COUNT_WIDTH -
                            traffic_analyzer_pkg::FRAME_SIZE_WIDTH){1'b0}}, frame_size};
    assign l2_octets    = {{(traffic_analyzer_pkg::OCTET_COUNT_WIDTH -
                            traffic_analyzer_pkg::FRAME_SIZE_WIDTH){1'b0}}, l2_size};

    // each frame lands in exactly one class
    always_comb begin
        pkts_nxt           = pkts_cnt;
        bad_crc_pkts_nxt   = bad_crc_pkts_cnt;
        bad_pre_pkts_nxt   = bad_pre_pkts_cnt;
        octets_nxt         = octets_cnt;
        bad_crc_octets_nxt = bad_crc_octets_cnt;
        bad_pre_octets_nxt = bad_pre_octets_cnt;
        if (!preamble_ok) begin
            bad_pre_pkts_nxt   = bad_pre_pkts_cnt + 1'b1;
            bad_pre_octets_nxt = bad_pre_octets_cnt + frame_octets;
        end else if (crc_ok) begin
            pkts_nxt   = pkts_cnt + 1'b1;
            octets_nxt = octets_cnt + l2_octets;
        end else begin
            bad_crc_pkts_nxt   = bad_crc_pkts_cnt + 1'b1;
            bad_crc_octets_nxt = bad_crc_octets_cnt + l2_octets;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn || !run) begin
            en_d                <= 1'b0;
            freeze_sync         <= 1'b0;
            pkts_cnt            <= '0;
            bad_crc_pkts_cnt    <= '0;
            bad_pre_pkts_cnt    <= '0;
            octets_cnt          <= '0;
            bad_crc_octets_cnt  <= '0;
            bad_pre_octets_cnt  <= '0;
            idle_cnt            <= '0;
            total_cnt           <= '0;
            pkts                <= '0;
            bad_crc_pkts        <= '0;
            bad_preamble_pkts   <= '0;
            octets              <= '0;
            bad_crc_octets      <= '0;
            bad_preamble_octets <= '0;
            octets_idle         <= '0;
            octets_total        <= '0;
        end else begin
            en_d <= gmii_en;
            // freeze as seen at the first octet
            if (gmii_en && !en_d) begin
                freeze_sync <= freeze;
            end

            if (frame_done) begin
                pkts_cnt           <= pkts_nxt;
                bad_crc_pkts_cnt   <= bad_crc_pkts_nxt;
                bad_pre_pkts_cnt   <= bad_pre_pkts_nxt;
                octets_cnt         <= octets_nxt;
                bad_crc_octets_cnt <= bad_crc_octets_nxt;
                bad_pre_octets_cnt <= bad_pre_octets_nxt;
                if (!freeze_sync) begin
                    pkts                <= pkts_nxt;
                    bad_crc_pkts        <= bad_crc_pkts_nxt;
                    bad_preamble_pkts   <= bad_pre_pkts_nxt;
                    octets              <= octets_nxt;
                    bad_crc_octets      <= bad_crc_octets_nxt;
                    bad_preamble_octets <= bad_pre_octets_nxt;
                end
            end

            // octet times
            if (!gmii_en) begin
                idle_cnt <= idle_cnt + 1'b1;
            end
            total_cnt <= total_cnt + 1'b1;
            if (!freeze) begin
                octets_idle  <= idle_cnt;
                octets_total <= total_cnt;
            end
        end
    end

endmodule

/* hdl/traffic_analyzer_gmii.sv */
`timescale 1ns/1ps

module traffic_analyzer_gmii (
    input  logic                                               clk,
    input  logic                                               resetn,
    input  logic [traffic_analyzer_pkg::GMII_DATA_WIDTH-1:0]   gmii_d,
    input  logic                                               gmii_en,
    input  logic                                               gmii_er,
    input  logic                                               run_in,
    input  logic                                               freeze_in,
    output logic [traffic_analyzer_pkg::PKT_COUNT_WIDTH-1:0]   pkts,
    output logic [traffic_analyzer_pkg::PKT_COUNT_WIDTH-1:0]   bad_crc_pkts,
    output logic [traffic_analyzer_pkg::PKT_COUNT_WIDTH-1:0]   bad_preamble_pkts,
    output logic [traffic_analyzer_pkg::OCTET_COUNT_WIDTH-1:0] octets,
    output logic [traffic_analyzer_pkg::OCTET_COUNT_WIDTH-1:0] bad_crc_octets,
    output logic [traffic_analyzer_pkg::OCTET_COUNT_WIDTH-1:0] bad_preamble_octets,
    output logic [traffic_analyzer_pkg::OCTET_COUNT_WIDTH-1:0] octets_idle,
    output logic [traffic_analyzer_pkg::OCTET_COUNT_WIDTH-1:0] octets_total
);

    logic run;
    logic freeze;

    logic                                              crc_ok;
    logic                                              preamble_ok;
    logic                                              frame_done;
    logic [traffic_analyzer_pkg::FRAME_SIZE_WIDTH-1:0] frame_size;
    logic [traffic_analyzer_pkg::FRAME_SIZE_WIDTH-1:0] l2_size;

    // control levels, one register stage
    always_ff @(posedge clk) begin
        if (!resetn) begin
            run    <= 1'b0;
            freeze <= 1'b0;
        end else begin
            run    <= run_in;
            freeze <= freeze_in;
        end
    end

    gmii_crc_check u_crc_check (
        .clk         (clk),
        .resetn      (resetn),
        .run         (run),
        .gmii_d      (gmii_d),
        .gmii_en     (gmii_en),
        .gmii_er     (gmii_er),
        .crc_ok      (crc_ok),
        .preamble_ok (preamble_ok)
    );

    gmii_frame_tracker u_frame_tracker (
        .clk         (clk),
        .resetn      (resetn),
        .run         (run),
        .gmii_en     (gmii_en),
        .preamble_ok (preamble_ok),
        .frame_done  (frame_done),
        .frame_size  (frame_size),
        .l2_size     (l2_size)
    );

    traffic_stats u_stats (
        .clk                 (clk),
        .resetn              (resetn),
        .run                 (run),
        .freeze              (freeze),
        .gmii_en             (gmii_en),
        .frame_done          (frame_done),
        .frame_size          (frame_size),
        .l2_size             (l2_size),
        .crc_ok              (crc_ok),
        .preamble_ok         (preamble_ok),
        .pkts                (pkts),
        .bad_crc_pkts        (bad_crc_pkts),
        .bad_preamble_pkts   (bad_preamble_pkts),
        .octets              (octets),
        .bad_crc_octets      (bad_crc_octets),
        .bad_preamble_octets (bad_preamble_octets),
        .octets_idle         (octets_idle),
        .octets_total        (octets_total)
    );

endmodule

/* tests/gmii_frame_model.svh */
// reference crc-32 constants
localparam logic [31:0] REF_CRC_POLY    = 32'hEDB88320;
localparam logic [31:0] REF_CRC_INIT    = 32'hFFFFFFFF;
localparam logic [31:0] REF_CRC_RESIDUE = 32'hDEBB20E3;
localparam int          REF_HEADER_LEN  = 8;

// frame kinds
localparam int KIND_GOOD    = 0;
localparam int KIND_BAD_FCS = 1;
localparam int KIND_ER      = 2;
localparam int KIND_BAD_PRE = 3;

// class index in output port order
localparam int CLS_GOOD = 0;
localparam int CLS_CRC  = 1;
localparam int CLS_PRE  = 2;

// internal counts and what the outputs should show
longint unsigned exp_pkts[3];
longint unsigned exp_octets[3];
longint unsigned pub_pkts[3];
longint unsigned pub_octets[3];

// bit serial, lsb first
function automatic logic [31:0] crc32_octet(input logic [31:0] crc_in, input logic [7:0] octet);
    logic [31:0] c;
    int          b;
    c = crc_in;
    for (b = 0; b < 8; b++) begin
        if (c[0] ^ octet[b]) begin
            c = (c >> 1) ^ REF_CRC_POLY;
        end else begin
            c = c >> 1;
        end
    end
    return c;
endfunction

task automatic build_frame(input int kind, input int payload_len);
    logic [31:0] crc;
    int          i;
    int          pos;
    tx_d.delete();
    tx_er.delete();
    for (i = 0; i < REF_HEADER_LEN - 1; i++) begin
        tx_d.push_back(8'h55);
    end
    tx_d.push_back(8'hD5);
    crc = REF_CRC_INIT;
    for (i = 0; i < payload_len; i++) begin
        tx_d.push_back(8'($urandom_range(255, 0)));
        crc = crc32_octet(crc, tx_d[tx_d.size() - 1]);
    end
    // fcs goes out lsb first
    crc = ~crc;
    for (i = 0; i < 4; i++) begin
        tx_d.push_back(crc[8*i +: 8]);
    end
    for (i = 0; i < tx_d.size(); i++) begin
        tx_er.push_back(1'b0);
    end
    if (kind == KIND_BAD_FCS) begin
        pos = tx_d.size() - 1 - int'($urandom_range(3, 0));
        tx_d[pos] = tx_d[pos] ^ (8'h01 << $urandom_range(7, 0));
    end else if (kind == KIND_ER) begin
        pos = int'($urandom_range(tx_d.size() - 1, REF_HEADER_LEN));
        tx_er[pos] = 1'b1;
    end else if (kind == KIND_BAD_PRE) begin
        pos = int'($urandom_range(REF_HEADER_LEN - 1, 0));
        tx_d[pos] = tx_d[pos] ^ 8'($urandom_range(255, 1));
    end
endtask

task automatic model_frame(input bit frozen);
    logic [31:0]     crc;
    bit              pre_good;
    bit              er_seen;
    int              cls;
    int              i;
    longint unsigned frame_len;
    longint unsigned add;
    frame_len = 64'(tx_d.size());
    pre_good  = 1'b1;
    er_seen   = 1'b0;
    crc       = REF_CRC_INIT;
    for (i = 0; i < tx_d.size(); i++) begin
        er_seen = er_seen | tx_er[i];
        if (i < REF_HEADER_LEN - 1) begin
            if (tx_d[i] != 8'h55) pre_good = 1'b0;
        end else if (i == REF_HEADER_LEN - 1) begin
            if (tx_d[i] != 8'hD5) pre_good = 1'b0;
        end else begin
            crc = crc32_octet(crc, tx_d[i]);
        end
    end
    if (!pre_good) begin
        cls = CLS_PRE;
        add = frame_len;
    end else if (!er_seen && crc == REF_CRC_RESIDUE) begin
        cls = CLS_GOOD;
        add = frame_len - REF_HEADER_LEN;
    end else begin
        cls = CLS_CRC;
        add = frame_len - REF_HEADER_LEN;
    end
    exp_pkts[cls]   += 1;
    exp_octets[cls] += add;
    if (!frozen) begin
        pub_pkts   = exp_pkts;
        pub_octets = exp_octets;
    end
endtask

task automatic model_clear();
    int i;
    for (i = 0; i < 3; i++) begin
        exp_pkts[i]   = 0;
        exp_octets[i] = 0;
    end
    pub_pkts   = exp_pkts;
    pub_octets = exp_octets;
endtask

/* tests/tb_traffic_analyzer.sv */
`timescale 1ns/1ps

module tb_traffic_analyzer;

    localparam int IDLE_GAP     = 12;
    localparam int WAIT_TIMEOUT = 20;
    // a frame result reaches the outputs within this many cycles
    localparam int STATS_LATENCY = 3;

    logic                                               clk;
    logic                                               resetn;
    logic [traffic_analyzer_pkg::GMII_DATA_WIDTH-1:0]   gmii_d;
    logic                                               gmii_en;
    logic                                               gmii_er;
    logic                                               run_in;
    logic                                               freeze_in;
    logic [traffic_analyzer_pkg::PKT_COUNT_WIDTH-1:0]   pkts;
    logic [traffic_analyzer_pkg::PKT_COUNT_WIDTH-1:0]   bad_crc_pkts;
    logic [traffic_analyzer_pkg::PKT_COUNT_WIDTH-1:0]   bad_preamble_pkts;
    logic [traffic_analyzer_pkg::OCTET_COUNT_WIDTH-1:0] octets;
    logic [traffic_analyzer_pkg::OCTET_COUNT_WIDTH-1:0] bad_crc_octets;
    logic [traffic_analyzer_pkg::OCTET_COUNT_WIDTH-1:0] bad_preamble_octets;
    logic [traffic_analyzer_pkg::OCTET_COUNT_WIDTH-1:0] octets_idle;
    logic [traffic_analyzer_pkg::OCTET_COUNT_WIDTH-1:0] octets_total;

    // octets and error flags of the frame being sent
    logic [7:0]      tx_d[$];
    logic            tx_er[$];
    // cycles with gmii_en high since run_in rose
    longint unsigned active_cycles;
    longint unsigned held[8];
    longint unsigned good_frames;
    longint unsigned good_octets;
    longint unsigned pkts_before;
    int              payload_len;
    string           test_name;

    `include "gmii_frame_model.svh"

    traffic_analyzer_gmii u_dut (.*);

    always #5 clk = ~clk;

    task automatic stop_with_error(input string reason);
        $display("%s", reason);
        $display("Something failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string what, input longint unsigned expected,
                               input longint unsigned actual);
        if (expected != actual) begin
            stop_with_error($sformatf("** Error [%s] %s: expected %0d, actual %0d",
                                      test_name, what, expected, actual));
        end
    endtask

    function automatic longint unsigned output_word(input int idx);
        case (idx)
            0:       return 64'(pkts);
            1:       return 64'(bad_crc_pkts);
            2:       return 64'(bad_preamble_pkts);
            3:       return octets;
            4:       return bad_crc_octets;
            5:       return bad_preamble_octets;
            6:       return octets_idle;
            default: return octets_total;
        endcase
    endfunction

    function automatic string output_name(input int idx);
        case (idx)
            0:       return "pkts";
            1:       return "bad_crc_pkts";
            2:       return "bad_preamble_pkts";
            3:       return "octets";
            4:       return "bad_crc_octets";
            5:       return "bad_preamble_octets";
            6:       return "octets_idle";
            default: return "octets_total";
        endcase
    endfunction

    task automatic idle_gap(input int cycles);
        int i;
        for (i = 0; i < cycles; i++) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic send_frame();
        int i;
        for (i = 0; i < tx_d.size(); i++) begin
            @(posedge clk);
            #1;
            gmii_d  = tx_d[i];
            gmii_er = tx_er[i];
            gmii_en = 1'b1;
        end
        @(posedge clk);
        #1;
        gmii_d  = '0;
        gmii_er = 1'b0;
        gmii_en = 1'b0;
        active_cycles += 64'(tx_d.size());
    endtask

    task automatic wait_for_stats();
        int n;
        n = 0;
        while (output_word(0) + output_word(1) + output_word(2) !=
               pub_pkts[0] + pub_pkts[1] + pub_pkts[2]) begin
            if (n == STATS_LATENCY) begin
                stop_with_error("packet counters did not update within 3 cycles after a frame");
            end else begin
                @(posedge clk);
                #1;
                n++;
            end
        end
    endtask

    task automatic wait_for_clear();
        int n;
        int i;
        bit clr;
        n   = 0;
        clr = 1'b0;
        while (!clr) begin
            clr = 1'b1;
            for (i = 0; i < 8; i++) begin
                if (output_word(i) != 0) clr = 1'b0;
            end
            if (!clr && n == WAIT_TIMEOUT) begin
                stop_with_error("timeout waiting for the outputs to clear with run low");
            end else if (!clr) begin
                @(posedge clk);
                #1;
                n++;
            end
        end
    endtask

    task automatic check_outputs();
        int i;
        for (i = 0; i < 3; i++) begin
            check_value(output_name(i), pub_pkts[i], output_word(i));
            check_value(output_name(i + 3), pub_octets[i], output_word(i + 3));
        end
        check_value("octets_total - octets_idle", active_cycles, octets_total - octets_idle);
    endtask

    task automatic run_frame(input int kind, input bit frozen);
        payload_len = int'($urandom_range(80, 20));
        build_frame(kind, payload_len);
        send_frame();
        model_frame(frozen);
        wait_for_stats();
        idle_gap(IDLE_GAP);
    endtask

    initial begin
        int i;
        void'($urandom(19));
        clk           = 1'b0;
        resetn        = 1'b0;
        gmii_d        = '0;
        gmii_en       = 1'b0;
        gmii_er       = 1'b0;
        run_in        = 1'b0;
        freeze_in     = 1'b0;
        active_cycles = 0;
        model_clear();

        test_name = "reset";
        idle_gap(3);
        resetn = 1'b1;
        idle_gap(2);
        check_outputs();
        run_in = 1'b1;
        idle_gap(3);

        test_name   = "good frames";
        good_frames = 0;
        good_octets = 0;
        repeat (6) begin
            run_frame(KIND_GOOD, 1'b0);
            good_frames++;
            good_octets += 64'(payload_len + 4);
            check_outputs();
        end
        check_value("pkts against frames sent", good_frames, output_word(0));
        check_value("octets against payload plus fcs", good_octets, output_word(3));

        test_name   = "bad crc";
        pkts_before = output_word(0);
        repeat (6) begin
            run_frame(($urandom_range(1, 0) == 0) ? KIND_BAD_FCS : KIND_ER, 1'b0);
            check_outputs();
        end
        check_value("pkts unchanged", pkts_before, output_word(0));

        test_name = "bad preamble";
        repeat (5) begin
            pkts_before = output_word(2);
            run_frame(KIND_BAD_PRE, 1'b0);
            check_value("bad_preamble_pkts step", pkts_before + 1, output_word(2));
            check_outputs();
        end

        // published values hold while the internal counters move on
        test_name = "freeze";
        freeze_in = 1'b1;
        idle_gap(3);
        for (i = 0; i < 8; i++) begin
            held[i] = output_word(i);
        end
        repeat (4) begin
            run_frame(int'($urandom_range(3, 0)), 1'b1);
            for (i = 0; i < 8; i++) begin
                check_value(output_name(i), held[i], output_word(i));
            end
        end
        freeze_in = 1'b0;
        idle_gap(3);
        run_frame(KIND_GOOD, 1'b0);
        check_outputs();

        test_name = "random mix";
        repeat (24) begin
            run_frame(int'($urandom_range(3, 0)), 1'b0);
            check_outputs();
        end

        test_name = "run clear";
        run_in = 1'b0;
        wait_for_clear();
        idle_gap(3);
        for (i = 0; i < 8; i++) begin
            check_value(output_name(i), 64'd0, output_word(i));
        end
        model_clear();
        active_cycles = 0;
        run_in = 1'b1;
        idle_gap(3);
        repeat (4) begin
            run_frame(int'($urandom_range(3, 0)), 1'b0);
            check_outputs();
        end

        $display("Everything OK");
        $finish;
    end

endmodule

/* all.f */
+incdir+tests
hdl/traffic_analyzer_pkg.sv
hdl/gmii_crc_check.sv
hdl/gmii_frame_tracker.sv
hdl/traffic_stats.sv
hdl/traffic_analyzer_gmii.sv
tests/tb_traffic_analyzer.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal -f all.f --top-module tb_traffic_analyzer \
    && ./obj_dir/Vtb_traffic_analyzer \
    || exit 1
